// File: hdl/dbg_mailbox.sv
// dbg_mailbox: holds the last finished scan for the SOC
// also decodes IR 0x38 scans as debugger commands
`timescale 1ns/10ps
`default_nettype none

module dbg_mailbox (
	input  wire                           clk48m,
	input  wire                           jrstn,
	input  wire                           xfer_strobe,
	input  wire dbg_pkg::dbg_xfer_t       xfer,
	output logic [jtag_pkg::DR_WIDTH-1:0] dbgreg_data,
	output logic                          dbgreg_sel,
	output logic                          dbgreg_strobe,
	output dbg_pkg::dbg_cmd_t             dbg_cmd,
	output logic                          cmd_strobe
);
	import dbg_pkg::*;

	logic is_cmd; // finished word came in under IR 0x38

	assign is_cmd = xfer_strobe && (xfer.sel == SEL_IR38);

	// raw word for the SOC, every scan
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			dbgreg_data   <= '0;
			dbgreg_sel    <= SEL_IR32;
			dbgreg_strobe <= 1'b0;
		end else begin
			dbgreg_strobe <= xfer_strobe; // plain pulse, SOC takes it or loses it
			if (xfer_strobe) begin
				dbgreg_data <= xfer.word.raw; // overwrite, no back-pressure
				dbgreg_sel  <= xfer.sel;
			end
		end
	end

	// command view of the same word
	// only IR 0x38 scans load it, so
	// a later IR 0x32 scan leaves the last command in place
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			dbg_cmd    <= '0;
			cmd_strobe <= 1'b0;
		end else begin
			cmd_strobe <= is_cmd; // lines up with dbgreg_strobe
			if (is_cmd) begin
				dbg_cmd <= xfer.word.cmd; // op, addr, arg split by the union
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/dbg_pkg.sv
// debug-side definitions
// finished scan word, its command view, and the user instruction select codes
`default_nettype none

package dbg_pkg;

	// command field sizes, arg takes whatever is left of the register
	localparam int CMD_OP_W   = 8;
	localparam int CMD_ADDR_W = 8;
	localparam int CMD_ARG_W  = jtag_pkg::DR_WIDTH - CMD_OP_W - CMD_ADDR_W;

	// which user instruction put the register in the scan path
	localparam logic SEL_IR32 = 1'b0;
	localparam logic SEL_IR38 = 1'b1;

	// debugger command, op in the top byte
	typedef struct packed {
		logic [CMD_OP_W-1:0]   op;   // command code
		logic [CMD_ADDR_W-1:0] addr; // target register
		logic [CMD_ARG_W-1:0]  arg;  // low half, operand
	} dbg_cmd_t;

	// one scanned word, read raw or as a command
	typedef union packed {
		logic [jtag_pkg::DR_WIDTH-1:0] raw;
		dbg_cmd_t                      cmd;
	} dbg_word_u;

	// finished scan as handed over to the mailbox
	typedef struct packed {
		logic      sel;  // SEL_IR32 or SEL_IR38
		dbg_word_u word;
	} dbg_xfer_t;

endpackage

`default_nettype wire

// File: hdl/dr_shifter.sv
// dr_shifter module holding the 32-bit user data register of the debug port
// tracks which user instruction selected it and captures the word on update
`timescale 1ns/10ps
`default_nettype none

module dr_shifter (
	input  wire                   clk48m,
	input  wire                   jrstn,
	input  wire                   tck_edge,
	input  wire jtag_pkg::jtag_pins_t pins,
	output logic                  xfer_strobe,
	output dbg_pkg::dbg_xfer_t    xfer
);
	import jtag_pkg::*;
	import dbg_pkg::*;

	logic [DR_WIDTH-1:0] dr;          // shift register, tdi enters at the top
	logic                shift_armed; // shift pin as stored at the previous edge
	logic                sel_work;    // select bit of the scan in progress
	logic                upd_edge;    // tck edge inside update-dr

	assign upd_edge = tck_edge && pins.update;

	// control side
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			shift_armed <= pins.shift; // follows the shift pin while in reset
			sel_work    <= SEL_IR32;
			xfer_strobe <= 1'b0;
		end else begin
			xfer_strobe <= upd_edge; // one clock after the update edge
			if (tck_edge) begin
				// shift-dr is entered on the tck that raises jshift, so that edge only arms
				shift_armed <= pins.shift;
				if (pins.ce1 || pins.ce2) begin
					sel_work <= pins.ce2 ? SEL_IR38 : SEL_IR32; // ce2 means IR 0x38
				end
			end
		end
	end

	// data side
	always_ff @(posedge clk48m) begin
		if (tck_edge && shift_armed) begin
			dr <= {pins.tdi, dr[DR_WIDTH-1:1]}; // right shift, lsb leaves first
		end
		if (upd_edge) begin
			xfer.word.raw <= dr;       // value before any shift on this edge
			xfer.sel      <= sel_work; // held until the next update
		end
	end

endmodule

`default_nettype wire

// File: hdl/jtag_dbg_top.sv
// jtag_dbg_top: JTAG debug-register bridge
// sampler, data register and mailbox with the wires between them
`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_top (
	input  wire                           clk48m,
	input  wire                           jrstn,
	input  wire                           jtck,
	input  wire                           jtdi,
	input  wire                           jshift,
	input  wire                           jupdate,
	input  wire                           jce1,
	input  wire                           jce2,
	output logic [jtag_pkg::DR_WIDTH-1:0] dbgreg_data,
	output logic                          dbgreg_sel,    // 0 for IR 0x32, 1 for IR 0x38
	output logic                          dbgreg_strobe,
	output dbg_pkg::dbg_cmd_t             dbg_cmd,
	output logic                          cmd_strobe
);
	import jtag_pkg::*;
	import dbg_pkg::*;

	wire             tck_edge;    // one pulse per jtck rise
	wire jtag_pins_t pins;        // pins valid with tck_edge
	wire             xfer_strobe; // scan finished
	wire dbg_xfer_t  xfer;        // finished word and its select

	tck_sampler u_sampler (
		.clk48m   (clk48m),
		.jrstn    (jrstn),
		.jtck     (jtck),
		.jtdi     (jtdi),
		.jshift   (jshift),
		.jupdate  (jupdate),
		.jce1     (jce1),
		.jce2     (jce2),
		.tck_edge (tck_edge),
		.pins     (pins)
	);

	dr_shifter u_shifter (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.tck_edge    (tck_edge),
		.pins        (pins),
		.xfer_strobe (xfer_strobe),
		.xfer        (xfer)
	);

	dbg_mailbox u_mailbox (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.xfer_strobe   (xfer_strobe),
		.xfer          (xfer),
		.dbgreg_data   (dbgreg_data),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_strobe (dbgreg_strobe),
		.dbg_cmd       (dbg_cmd),
		.cmd_strobe    (cmd_strobe)
	);

endmodule

`default_nettype wire

// File: hdl/jtag_pkg.sv
// pin-side definitions for the JTAG debug bridge
// sampled controller pins, oversampler depth, data register width
`default_nettype none

package jtag_pkg;

	localparam int TCK_SYNC_DEPTH = 4;  // jtck oversampling stages
	localparam int DR_WIDTH       = 32; // bits in the user data register

	// controller pins as seen at one tck edge
	typedef struct packed {
		logic tdi;    // scan data in, lsb first
		logic shift;  // controller sits in shift-dr
		logic update; // high for one tck in update-dr
		logic ce1;    // register picked by IR 0x32
		logic ce2;    // register picked by IR 0x38
	} jtag_pins_t;

endpackage

`default_nettype wire

// File: hdl/tck_sampler.sv
// tck_sampler: oversamples the slow JTAG clock in the 48 MHz domain
// gives a one-cycle pulse per jtck rise, plus the controller pins
`timescale 1ns/10ps
`default_nettype none

module tck_sampler (
	input  wire                   clk48m,
	input  wire                   jrstn,
	input  wire                   jtck,
	input  wire                   jtdi,
	input  wire                   jshift,
	input  wire                   jupdate,
	input  wire                   jce1,
	input  wire                   jce2,
	output logic                  tck_edge,
	output jtag_pkg::jtag_pins_t  pins
);
	import jtag_pkg::*;

	logic [TCK_SYNC_DEPTH-1:0] tck_sync; // jtck history, bit 0 is the newest sample

	// jtck is asynchronous, walk it down the chain
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_sync <= '0;
		end else begin
			tck_sync <= {tck_sync[TCK_SYNC_DEPTH-2:0], jtck};
		end
	end

	// rise seen at the far end of the chain, i.e. somewhat after the real edge.
	// by then tdi and the control pins have long settled
	assign tck_edge = !tck_sync[TCK_SYNC_DEPTH-1] && tck_sync[TCK_SYNC_DEPTH-2];

	// controller pins, registered every cycle
	always_ff @(posedge clk48m) begin
		pins.tdi    <= jtdi;
		pins.shift  <= jshift;
		pins.update <= jupdate;  // one tck wide at the controller
		pins.ce1    <= jce1;
		pins.ce2    <= jce2;
	end

endmodule

`default_nettype wire

// File: jtag_dbg.f
hdl/jtag_pkg.sv
hdl/dbg_pkg.sv
hdl/tck_sampler.sv
hdl/dr_shifter.sv
hdl/dbg_mailbox.sv
hdl/jtag_dbg_top.sv
verif/tb_jtag_dbg.sv

// File: verif/jtag_dbg_trace.txt
// columns: select (0 = IR 0x32, 1 = IR 0x38), word shifted lsb first,
//          expected dbgreg_data, command expected (1 = cmd_strobe and dbg_cmd load)
// a select of ff ends the trace
// raw word, then a command, then a raw word that must keep the command
0  a5c30f1e  a5c30f1e  0
1  01200004  01200004  1
0  deadbeef  deadbeef  0
0  00000001  00000001  0
// alternating selects from here
1  ff00ffff  ff00ffff  1
0  80000000  80000000  0
1  12345678  12345678  1
0  fedcba98  fedcba98  0
1  7e5a0c33  7e5a0c33  1
0  00000000  00000000  0
1  c0ffee01  c0ffee01  1
0  55555555  55555555  0
1  aaaaaaaa  aaaaaaaa  1
0  0badf00d  0badf00d  0
1  3c3c5a5a  3c3c5a5a  1
0  ffffffff  ffffffff  0
1  02010203  02010203  1
0  9e3779b9  9e3779b9  0
1  4f1bbcdc  4f1bbcdc  1
0  13579bdf  13579bdf  0
1  2468ace0  2468ace0  1
0  6b8b4567  6b8b4567  0
1  327b23c6  327b23c6  1
0  643c9869  643c9869  0
1  66334873  66334873  1
0  74b0dc51  74b0dc51  0
1  19495cff  19495cff  1
0  2ae8944a  2ae8944a  0
1  625558ec  625558ec  1
0  238e1f29  238e1f29  0
1  46e87ccd  46e87ccd  1
ff 00000000  00000000  0

// File: verif/tb_jtag_dbg.sv
// testbench for the JTAG debug-register bridge
// bit-bangs user DR scans from the trace file, checks mailbox words and commands
`timescale 1ns/10ps
`default_nettype none

module tb_jtag_dbg;
	import jtag_pkg::*;
	import dbg_pkg::*;

	localparam int          TRACE_DEPTH    = 256;          // four words per trace line
	localparam int          MAX_SCANS      = TRACE_DEPTH / 4;
	localparam logic [31:0] END_MARK       = 32'h0000_00ff; // select column of the last line
	localparam int          BASE_HALF      = 8;            // jtck half period in clk48m cycles
	localparam int          STROBE_TIMEOUT = 200;

	logic                clk48m;
	logic                jrstn;
	logic                jtck;
	logic                jtdi;
	logic                jshift;
	logic                jupdate;
	logic                jce1;
	logic                jce2;
	logic [DR_WIDTH-1:0] dbgreg_data;
	logic                dbgreg_sel;
	logic                dbgreg_strobe;
	dbg_cmd_t            dbg_cmd;
	logic                cmd_strobe;

	logic [31:0] trace_mem [0:TRACE_DEPTH-1];
	int          dbg_pulses; // dbgreg_strobe pulses since reset
	int          cmd_pulses; // cmd_strobe pulses since reset
	dbg_cmd_t    last_cmd;   // command expected to be held in dbg_cmd

	jtag_dbg_top dut0 (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.jtck          (jtck),
		.jtdi          (jtdi),
		.jshift        (jshift),
		.jupdate       (jupdate),
		.jce1          (jce1),
		.jce2          (jce2),
		.dbgreg_data   (dbgreg_data),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_strobe (dbgreg_strobe),
		.dbg_cmd       (dbg_cmd),
		.cmd_strobe    (cmd_strobe)
	);

	initial begin
		clk48m = 1'b0;
		forever #20 clk48m = ~clk48m; // 40 ns period
	end

	// strobe counters, each edge sees the level held over the cycle before it
	always @(posedge clk48m) begin
		if (jrstn === 1'b1) begin
			if (dbgreg_strobe === 1'b1) dbg_pulses++;
			if (cmd_strobe === 1'b1) cmd_pulses++;
		end
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input dbg_xfer_t expected);
		if (dbgreg_data !== expected.word.raw) begin
			report_failure($sformatf("CHECK FAILED dbgreg_data got %h expected %h",
				dbgreg_data, expected.word.raw));
		end
		if (dbgreg_sel !== expected.sel) begin
			report_failure($sformatf("CHECK FAILED dbgreg_sel got %h expected %h",
				dbgreg_sel, expected.sel));
		end
	endtask

	task automatic check_cmd(input dbg_cmd_t expected);
		if (dbg_cmd !== expected) begin
			report_failure($sformatf(
				"CHECK FAILED dbg_cmd got %h expected %h (op %h addr %h arg %h)",
				dbg_cmd, expected, expected.op, expected.addr, expected.arg));
		end
	endtask

	task automatic check_pulses(input string name, input int got, input int expected);
		if (got != expected) begin
			report_failure($sformatf("CHECK FAILED %s pulse count got %0h expected %0h",
				name, got, expected));
		end
	endtask

	// one jtck period, pins set while jtck is low, jittered half periods
	task automatic pulse_tck(input logic tdi, input logic shift, input logic update,
	                         input logic ce1, input logic ce2);
		int half;
		@(posedge clk48m);
		jtdi    <= tdi;
		jshift  <= shift;
		jupdate <= update;
		jce1    <= ce1;
		jce2    <= ce2;
		half = BASE_HALF + $urandom_range(3, 0);
		repeat (half) @(posedge clk48m);
		jtck <= 1'b1;
		half = BASE_HALF + $urandom_range(3, 0);
		repeat (half) @(posedge clk48m);
		jtck <= 1'b0;
	endtask

	// select, arm, 32 data bits lsb first, update
	task automatic scan_word(input logic sel, input logic [DR_WIDTH-1:0] word);
		pulse_tck(1'b0, 1'b0, 1'b0, !sel, sel);
		pulse_tck(~word[0], 1'b1, 1'b0, 1'b0, 1'b0); // arming tck, its tdi must be dropped
		for (int i = 0; i < DR_WIDTH; i++) begin
			pulse_tck(word[i], 1'b1, 1'b0, 1'b0, 1'b0);
		end
		pulse_tck(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		@(posedge clk48m);
		jupdate <= 1'b0;
	endtask

	task automatic wait_for_strobe(input int start_count);
		int waited;
		waited = 0;
		while (dbg_pulses == start_count && waited < STROBE_TIMEOUT) begin
			@(negedge clk48m);
			waited++;
		end
		if (dbg_pulses == start_count) begin
			report_failure("no strobe seen within 200 cycles after the update TCK");
		end
	endtask

	task automatic run_trace_line(input logic sel, input logic [DR_WIDTH-1:0] word,
	                              input logic [DR_WIDTH-1:0] exp_data, input logic exp_cmd);
		int        dbg_start;
		int        cmd_start;
		dbg_xfer_t xfer_exp;
		dbg_start = dbg_pulses;
		cmd_start = cmd_pulses;
		scan_word(sel, word);
		wait_for_strobe(dbg_start);
		repeat (2) @(posedge clk48m); // lets a stray second pulse show up
		@(negedge clk48m);
		check_pulses("dbgreg_strobe", dbg_pulses - dbg_start, 1);
		check_pulses("cmd_strobe", cmd_pulses - cmd_start, exp_cmd ? 1 : 0);
		xfer_exp.sel      = sel;
		xfer_exp.word.raw = exp_data;
		check_data(xfer_exp);
		if (exp_cmd) begin
			last_cmd.op   = exp_data[31:24]; // top byte
			last_cmd.addr = exp_data[23:16];
			last_cmd.arg  = exp_data[15:0];  // low half
		end
		check_cmd(last_cmd); // IR 0x32 scans must leave it alone
	endtask

	initial begin : main_flow
		logic [31:0] sel_col;
		dbg_xfer_t   zero_xfer;
		int          scans;
		bit          done;
		void'($urandom(32'hc1376531));
		jrstn      = 1'b0;
		jtck       = 1'b0;
		jtdi       = 1'b0;
		jshift     = 1'b0;
		jupdate    = 1'b0;
		jce1       = 1'b0;
		jce2       = 1'b0;
		dbg_pulses = 0;
		cmd_pulses = 0;
		last_cmd   = '0;
		$readmemh("verif/jtag_dbg_trace.txt", trace_mem);
		repeat (10) @(posedge clk48m);
		jrstn <= 1'b1;

		// idle after reset, nothing may come out
		repeat (50) @(posedge clk48m);
		@(negedge clk48m);
		check_pulses("dbgreg_strobe", dbg_pulses, 0);
		check_pulses("cmd_strobe", cmd_pulses, 0);
		zero_xfer = '0;
		check_data(zero_xfer);
		check_cmd(last_cmd);

		// scans back to back, straight from the trace
		scans = 0;
		done  = 1'b0;
		while (!done) begin
			sel_col = trace_mem[scans*4];
			if (scans == MAX_SCANS || sel_col === END_MARK) begin
				done = 1'b1;
			end else if (sel_col !== 32'h0 && sel_col !== 32'h1) begin
				report_failure("trace select is not 0, 1 or the ff end mark");
			end else begin
				run_trace_line(sel_col[0], trace_mem[scans*4+1], trace_mem[scans*4+2],
					trace_mem[scans*4+3][0]);
				scans++;
			end
		end

		if (scans == 0) begin
			report_failure("trace file held no scans");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
